/* sources.f */
mipsPkg.sv
Controller.sv
InstrQueue.sv
IssueFsm.sv
HazardUnit.sv
MduTimer.sv
MduDatapath.sv
DecodeIssue.sv
tbDecodeIssue.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --timescale 1ns/100ps --top-module tbDecodeIssue \
    -f sources.f -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

/* tbDecodeIssue.sv */
`timescale 1ns/100ps

module tbDecodeIssue;
    import mipsPkg::*;

    localparam int WAIT_LIMIT = 60;
    localparam logic [5:0] R_FNS [16] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU,
        FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MFHI, FN_MFLO, FN_MTHI, FN_MTLO, FN_JR, FN_JALR};
    localparam logic [5:0] I_OPS [15] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_LUI, OP_BEQ, OP_BNE,
        OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB, OP_LWER, OP_J, OP_JAL};
    localparam logic [5:0] MD_FNS [4] = '{FN_MULT, FN_MULTU, FN_DIV, FN_DIVU};

    logic    clk;
    logic    rstN;
    logic    inValid;
    instrT   inIns;
    wordT    inRs;
    wordT    inRt;
    logic    creditReturn;
    logic    issueValid;
    instrT   issueIns;
    regAddrT issueA3;
    aluOpT   issueAluOp;
    logic    issueAluB;
    logic    issueImmExt;
    logic    issueDmWe;
    widthT   issueDmWidth;
    logic    mduBusy;
    wordT    mfData;

    int      credits = 0;
    int      errors = 0;
    int      issuedTotal = 0;
    int      cycle = 0;
    instrT   loggedIns[$];
    int      loggedCycle[$];

    DecodeIssue DecodeIssue_i (
        .clk(clk), .rstN(rstN), .inValid(inValid), .inIns(inIns), .inRs(inRs), .inRt(inRt),
        .creditReturn(creditReturn), .issueValid(issueValid), .issueIns(issueIns),
        .issueA3(issueA3), .issueAluOp(issueAluOp), .issueAluB(issueAluB),
        .issueImmExt(issueImmExt), .issueDmWe(issueDmWe), .issueDmWidth(issueDmWidth),
        .mduBusy(mduBusy), .mfData(mfData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic reportError(input string msg);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    task automatic failTimeout(input string what);
        $display("Timed out at %0t ns waiting for %s", $time, what);
        $display("Test failures found");
        $finish;
    endtask

    // Credits come back and issues are logged mid-cycle
    always @(negedge clk) begin
        if (rstN) begin
            if (creditReturn) begin
                credits++;
            end
            if (credits < 0 || credits > QUEUE_DEPTH) begin
                reportError($sformatf("driver credit count %0d out of range", credits));
            end
            if (issueValid) begin
                loggedIns.push_back(issueIns);
                loggedCycle.push_back(cycle);
                issuedTotal++;
            end
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic applyReset();
        rstN    = 1'b0;
        inValid = 1'b0;
        repeat (3) begin
            nextCycle();
        end
        credits = QUEUE_DEPTH;
        rstN    = 1'b1;
    endtask

    // Spends one credit, waiting for one if none is held
    task automatic sendInstr(input instrT ins, input wordT rsVal, input wordT rtVal);
        int n;
        n = 0;
        while (credits == 0) begin
            inValid = 1'b0;
            nextCycle();
            n++;
            if (n > WAIT_LIMIT) begin
                failTimeout("a returned credit");
            end
        end
        inValid = 1'b1;
        inIns   = ins;
        inRs    = rsVal;
        inRt    = rtVal;
        credits--;
        nextCycle();
        inValid = 1'b0;
    endtask

    task automatic waitIssueOf(input instrT ins);
        int n;
        n = 0;
        while (!(issueValid && issueIns === ins)) begin
            nextCycle();
            n++;
            if (n > WAIT_LIMIT) begin
                failTimeout($sformatf("instruction %h to issue", ins));
            end
        end
    endtask

    task automatic waitLogSize(input int size);
        int n;
        n = 0;
        while (loggedIns.size() < size) begin
            nextCycle();
            n++;
            if (n > WAIT_LIMIT) begin
                failTimeout($sformatf("%0d issued instructions", size));
            end
        end
    endtask

    function automatic instrT rIns(input regAddrT rs, input regAddrT rt, input regAddrT rd,
                                   input logic [5:0] fn);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic instrT iIns(input logic [5:0] op, input regAddrT rs, input regAddrT rt,
                                   input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Reference decode by instruction class
    task automatic expectDecode(input instrT ins, output regAddrT a3, output aluOpT op,
                                output logic immB, output logic sext, output logic we,
                                output widthT w);
        logic [5:0] opc;
        logic       calI;
        logic       load;
        logic       store;
        opc   = ins[31:26];
        calI  = opc inside {OP_ADDI, OP_ANDI, OP_ORI, OP_LUI};
        load  = opc inside {OP_LW, OP_LH, OP_LB};
        store = opc inside {OP_SW, OP_SH, OP_SB};
        immB  = calI || load || store || opc == OP_LWER;
        sext  = opc == OP_ADDI || load || store || opc == OP_LWER;
        we    = store;
        w     = (opc inside {OP_LB, OP_SB}) ? 2'd2 : (opc inside {OP_LH, OP_SH}) ? 2'd1 : 2'd0;
        a3    = (calI || load) ? ins[20:16] : (opc == OP_JAL) ? 5'd31 : 5'd0;
        op    = (opc == OP_ANDI) ? 4'd2 : (opc == OP_ORI) ? 4'd3 : (opc == OP_LUI) ? 4'd4 : 4'd0;
        if (opc == OP_RTYPE) begin
            if (ins[5:0] inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU, FN_MFHI, FN_MFLO})
                a3 = ins[15:11];
            else if (ins[5:0] == FN_JALR)
                a3 = 5'd31;
            case (ins[5:0])
                FN_SUB:  op = 4'd1;
                FN_AND:  op = 4'd2;
                FN_OR:   op = 4'd3;
                FN_SLT:  op = 4'd5;
                FN_SLTU: op = 4'd6;
                default: op = 4'd0;
            endcase
        end
    endtask

    task automatic mduModel(input int kind, input wordT a, input wordT b,
                            output wordT hi, output wordT lo);
        longint          sp;
        longint unsigned up;
        sp = longint'(int'(a)) * longint'(int'(b));
        up = {32'd0, a} * {32'd0, b};
        case (kind)
            0: {hi, lo} = sp;
            1: {hi, lo} = up;
            2: begin
                lo = int'(a) / int'(b);
                hi = int'(a) % int'(b);
            end
            default: begin
                lo = a / b;
                hi = a % b;
            end
        endcase
    endtask

    task automatic decodeOne(input instrT ins);
        regAddrT a3;
        aluOpT   op;
        logic    immB;
        logic    sext;
        logic    we;
        widthT   w;
        expectDecode(ins, a3, op, immB, sext, we, w);
        sendInstr(ins, $urandom, $urandom);
        waitIssueOf(ins);
        if ({issueA3, issueAluOp, issueAluB, issueImmExt, issueDmWe, issueDmWidth}
                !== {a3, op, immB, sext, we, w}) begin
            reportError($sformatf(
                "decode of %h: a3 %0d op %0d b %b ext %b we %b w %0d, exp %0d %0d %b %b %b %0d",
                ins, issueA3, issueAluOp, issueAluB, issueImmExt, issueDmWe, issueDmWidth,
                a3, op, immB, sext, we, w));
        end
        nextCycle();
    endtask

    // Sends mflo then mfhi and checks the read data
    task automatic readBack(input wordT expHi, input wordT expLo, input string what);
        instrT lo;
        instrT hi;
        lo = rIns(5'd0, 5'd0, 5'd20, FN_MFLO);
        hi = rIns(5'd0, 5'd0, 5'd21, FN_MFHI);
        sendInstr(lo, 32'd0, 32'd0);
        waitIssueOf(lo);
        if (mfData !== expLo) begin
            reportError($sformatf("%s: LO %h, expected %h", what, mfData, expLo));
        end
        nextCycle();
        sendInstr(hi, 32'd0, 32'd0);
        waitIssueOf(hi);
        if (mfData !== expHi) begin
            reportError($sformatf("%s: HI %h, expected %h", what, mfData, expHi));
        end
        nextCycle();
    endtask

    task automatic checkGap(input int first, input int expGap, input string what);
        if (loggedCycle[first + 1] - loggedCycle[first] != expGap) begin
            reportError($sformatf("%s: issue gap %0d cycles, expected %0d", what,
                loggedCycle[first + 1] - loggedCycle[first], expGap));
        end
    endtask

    task automatic testDecodeTable();
        for (int i = 0; i < 16; i++) begin
            decodeOne(rIns(5'd1, 5'd2, 5'(10 + i), R_FNS[i]));
        end
        for (int i = 0; i < 15; i++) begin
            decodeOne(iIns(I_OPS[i], 5'd1, 5'(10 + i), 16'(16'h8000 + i)));
        end
    endtask

    task automatic testOrderCredits();
        instrT sent[$];
        loggedIns.delete();
        loggedCycle.delete();
        for (int k = 0; k < 12; k++) begin
            sent.push_back(iIns(OP_ORI, 5'd0, 5'(k + 3), 16'(k * 7)));
            sendInstr(sent[k], 32'd0, 32'd0);
        end
        waitLogSize(12);
        for (int k = 0; k < 12; k++) begin
            if (loggedIns[k] !== sent[k]) begin
                reportError($sformatf("issue %0d was %h, expected %h", k, loggedIns[k],
                    sent[k]));
            end
        end
        if (credits != QUEUE_DEPTH) begin
            reportError($sformatf("%0d credits held after drain, expected %0d", credits,
                QUEUE_DEPTH));
        end
    endtask

    task automatic testHazards();
        loggedIns.delete();
        loggedCycle.delete();
        sendInstr(iIns(OP_LW, 5'd1, 5'd8, 16'd4), 32'd0, 32'd0);
        sendInstr(rIns(5'd8, 5'd2, 5'd12, FN_ADD), 32'd0, 32'd0);
        sendInstr(iIns(OP_LW, 5'd1, 5'd9, 16'd8), 32'd0, 32'd0);
        sendInstr(rIns(5'd1, 5'd2, 5'd13, FN_ADD), 32'd0, 32'd0);
        sendInstr(rIns(5'd1, 5'd2, 5'd14, FN_SUB), 32'd0, 32'd0);
        sendInstr(rIns(5'd14, 5'd2, 5'd15, FN_OR), 32'd0, 32'd0);
        waitLogSize(6);
        checkGap(0, 3, "load then dependent add");
        checkGap(2, 1, "load then independent add");
        checkGap(4, 2, "ALU then dependent or");
    endtask

    task automatic testMdu();
        wordT  a;
        wordT  b;
        wordT  expHi;
        wordT  expLo;
        instrT ins;
        int    n;
        int    busy;
        for (int k = 0; k < 4; k++) begin
            a = $urandom;
            b = $urandom;
            // Small nonzero divisor for a useful quotient
            if (k >= 2) begin
                b = (b >> 16) | 32'd1;
            end
            mduModel(k, a, b, expHi, expLo);
            ins = rIns(5'd1, 5'd2, 5'd0, MD_FNS[k]);
            sendInstr(ins, a, b);
            n = 0;
            while (!mduBusy) begin
                nextCycle();
                n++;
                if (n > WAIT_LIMIT) begin
                    failTimeout("mduBusy to rise");
                end
            end
            busy = 0;
            while (mduBusy) begin
                busy++;
                nextCycle();
                if (busy > WAIT_LIMIT) begin
                    failTimeout("mduBusy to fall");
                end
            end
            if (busy != ((k < 2) ? MULT_CYCLES : DIV_CYCLES)) begin
                reportError($sformatf("op %0d kept mduBusy %0d cycles", k, busy));
            end
            readBack(expHi, expLo, $sformatf("op %0d on %h, %h", k, a, b));
        end
    endtask

    task automatic testMovesAndReset();
        wordT x;
        wordT y;
        x = $urandom;
        y = $urandom;
        sendInstr(rIns(5'd1, 5'd0, 5'd0, FN_MTHI), x, 32'd0);
        sendInstr(rIns(5'd1, 5'd0, 5'd0, FN_MTLO), y, 32'd0);
        readBack(x, y, "mthi and mtlo");
        // Reset with a divide running and work queued
        sendInstr(rIns(5'd1, 5'd2, 5'd0, FN_DIVU), x, 32'd3);
        sendInstr(rIns(5'd0, 5'd0, 5'd22, FN_MFLO), 32'd0, 32'd0);
        sendInstr(iIns(OP_ORI, 5'd0, 5'd23, 16'd5), 32'd0, 32'd0);
        applyReset();
        if ({issueValid, creditReturn, mduBusy} !== 3'b000) begin
            reportError($sformatf("after reset issueValid %b creditReturn %b mduBusy %b",
                issueValid, creditReturn, mduBusy));
        end
        readBack(32'd0, 32'd0, "after reset");
    endtask

    initial begin
        void'($urandom(40882));
        rstN    = 1'b0;
        inValid = 1'b0;
        inIns   = '0;
        inRs    = '0;
        inRt    = '0;
        applyReset();
        testDecodeTable();
        testOrderCredits();
        testHazards();
        testMdu();
        testMovesAndReset();
        $display("Finished: %0d instructions issued, %0d errors", issuedTotal, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* DecodeIssue.sv */
`timescale 1ns/100ps

module DecodeIssue (
    input  logic             clk,
    input  logic             rstN,
    input  logic             inValid,
    input  mipsPkg::instrT   inIns,
    input  mipsPkg::wordT    inRs,
    input  mipsPkg::wordT    inRt,
    output logic             creditReturn,
    output logic             issueValid,
    output mipsPkg::instrT   issueIns,
    output mipsPkg::regAddrT issueA3,
    output mipsPkg::aluOpT   issueAluOp,
    output logic             issueAluB,
    output logic             issueImmExt,
    output logic             issueDmWe,
    output mipsPkg::widthT   issueDmWidth,
    output logic             mduBusy,
    output mipsPkg::wordT    mfData
);
    import mipsPkg::*;

    instrT      headIns;
    wordT       headRs;
    wordT       headRt;
    logic       notEmpty;
    logic       pop;
    logic       issueFire;
    logic       regStall;
    logic       isMDFT;
    regAddrT    a3;
    tStageT     tuseRs;
    tStageT     tuseRt;
    tStageT     tnew;
    logic       aluB;
    logic       aluImmExt;
    aluOpT      aluOp;
    logic       mduStart;
    mduOpT      mduOp;
    logic       hiWrite;
    logic       loWrite;
    logic [1:0] outSelectE;
    logic       dmWe;
    widthT      dmWidth;
    logic       isReadRs;
    logic       isReadRt;

    InstrQueue InstrQueue_i (
        .clk(clk), .rstN(rstN), .push(inValid), .pushIns(inIns), .pushRs(inRs),
        .pushRt(inRt), .pop(pop), .headIns(headIns), .headRs(headRs), .headRt(headRt),
        .notEmpty(notEmpty)
    );

    // Branch and writeback controls have no consumer in this stage
    Controller Controller_i (
        .ins(headIns), .isJReg(), .isJ(), .isBranch(), .cmpSelect(), .isMDFT(isMDFT),
        .linkSelect(), .a3(a3), .tuseRs(tuseRs), .tuseRt(tuseRt), .tnew(tnew),
        .aluB(aluB), .aluImmExt(aluImmExt), .aluOp(aluOp), .mduStart(mduStart),
        .mduOp(mduOp), .hiWrite(hiWrite), .loWrite(loWrite), .outSelectE(outSelectE),
        .dmWe(dmWe), .dmWidth(dmWidth), .outSelectM(), .isReadRs(isReadRs),
        .isReadRt(isReadRt)
    );

    IssueFsm IssueFsm_i (
        .clk(clk), .rstN(rstN), .notEmpty(notEmpty), .regStall(regStall),
        .isMDFT(isMDFT), .mduBusy(mduBusy), .pop(pop), .creditReturn(creditReturn),
        .issueFire(issueFire)
    );

    HazardUnit HazardUnit_i (
        .clk(clk), .rstN(rstN), .issueFire(issueFire), .a3(a3), .tnew(tnew),
        .rs(headIns[25:21]), .rt(headIns[20:16]), .tuseRs(tuseRs), .tuseRt(tuseRt),
        .isReadRs(isReadRs), .isReadRt(isReadRt), .regStall(regStall)
    );

    // Unit acts only on the instruction that actually issues
    MduTimer MduTimer_i (
        .clk(clk), .rstN(rstN), .start(mduStart && issueFire), .isDiv(mduOp[1]),
        .mduBusy(mduBusy)
    );

    MduDatapath MduDatapath_i (
        .clk(clk), .rstN(rstN), .start(mduStart && issueFire), .mduOp(mduOp),
        .hiWrite(hiWrite && issueFire), .loWrite(loWrite && issueFire),
        .outSelectE(issueFire ? outSelectE : 2'd0), .opA(headRs), .opB(headRt),
        .mfData(mfData)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            issueValid <= 1'b0;
            issueDmWe  <= 1'b0;
        end else begin
            issueValid <= issueFire;
            issueDmWe  <= issueFire && dmWe;
        end
    end

    always_ff @(posedge clk) begin
        if (issueFire) begin
            issueIns     <= headIns;
            issueA3      <= a3;
            issueAluOp   <= aluOp;
            issueAluB    <= aluB;
            issueImmExt  <= aluImmExt;
            issueDmWidth <= dmWidth;
        end
    end

endmodule

/* MduDatapath.sv */
`timescale 1ns/100ps

module MduDatapath (
    input  logic           clk,
    input  logic           rstN,
    input  logic           start,
    input  mipsPkg::mduOpT mduOp,
    input  logic           hiWrite,
    input  logic           loWrite,
    input  logic [1:0]     outSelectE,
    input  mipsPkg::wordT  opA,
    input  mipsPkg::wordT  opB,
    output mipsPkg::wordT  mfData
);
    import mipsPkg::*;

    logic [63:0] product;
    wordT        quotient;
    wordT        remainder;
    wordT        hi;
    wordT        lo;

    always_comb begin
        product   = '0;
        quotient  = '0;
        remainder = '0;
        case (mduOp)
            MDU_MULT:  product = $signed({{32{opA[31]}}, opA}) * $signed({{32{opB[31]}}, opB});
            MDU_MULTU: product = {32'b0, opA} * {32'b0, opB};
            MDU_DIV: begin
                if (opB != '0) begin
                    quotient  = $signed(opA) / $signed(opB);
                    remainder = $signed(opA) % $signed(opB);
                end
            end
            MDU_DIVU: begin
                if (opB != '0) begin
                    quotient  = opA / opB;
                    remainder = opA % opB;
                end
            end
            default: product = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hi     <= '0;
            lo     <= '0;
            mfData <= '0;
        end else begin
            // Timer hides the result until the latency has passed
            if (start && !mduOp[1]) begin
                hi <= product[63:32];
                lo <= product[31:0];
            end else if (start && opB != '0) begin
                hi <= remainder;
                lo <= quotient;
            end
            if (hiWrite) begin
                hi <= opA;
            end
            if (loWrite) begin
                lo <= opA;
            end
            mfData <= (outSelectE == 2'd2) ? hi : (outSelectE == 2'd3) ? lo : '0;
        end
    end

endmodule

/* MduTimer.sv */
`timescale 1ns/100ps

module MduTimer (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic isDiv,
    output logic mduBusy
);
    import mipsPkg::*;

    logic [MDU_CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (start) begin
            count <= isDiv ? MDU_CNT_W'(DIV_CYCLES) : MDU_CNT_W'(MULT_CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign mduBusy = (count != '0);

endmodule

/* HazardUnit.sv */
`timescale 1ns/100ps

module HazardUnit (
    input  logic             clk,
    input  logic             rstN,
    input  logic             issueFire,
    input  mipsPkg::regAddrT a3,
    input  mipsPkg::tStageT  tnew,
    input  mipsPkg::regAddrT rs,
    input  mipsPkg::regAddrT rt,
    input  mipsPkg::tStageT  tuseRs,
    input  mipsPkg::tStageT  tuseRt,
    input  logic             isReadRs,
    input  logic             isReadRt,
    output logic             regStall
);
    import mipsPkg::*;

    regAddrT exeA3;
    regAddrT memA3;
    tStageT  exeTnew;
    tStageT  memTnew;
    tStageT  exeLeft;
    tStageT  memLeft;

    function automatic logic conflict(regAddrT src, logic isRead, tStageT tuse,
                                      regAddrT dst, tStageT left);
        // Value still short when the consumer reaches its use stage
        return isRead && (src != '0) && (src == dst) && (left != '0) && (tuse <= left);
    endfunction

    // Stages left before the producer's result exists
    assign exeLeft = (exeTnew > 2'd1) ? exeTnew - 2'd1 : 2'd0;
    assign memLeft = (memTnew > 2'd2) ? memTnew - 2'd2 : 2'd0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exeA3   <= '0;
            exeTnew <= '0;
            memA3   <= '0;
            memTnew <= '0;
        end else begin
            memA3   <= exeA3;
            memTnew <= exeTnew;
            // Bubble enters the execute slot when nothing issues
            exeA3   <= issueFire ? a3 : '0;
            exeTnew <= issueFire ? tnew : '0;
        end
    end

    assign regStall = conflict(rs, isReadRs, tuseRs, exeA3, exeLeft)
                   || conflict(rs, isReadRs, tuseRs, memA3, memLeft)
                   || conflict(rt, isReadRt, tuseRt, exeA3, exeLeft)
                   || conflict(rt, isReadRt, tuseRt, memA3, memLeft);

endmodule

/* IssueFsm.sv */
`timescale 1ns/100ps

module IssueFsm (
    input  logic clk,
    input  logic rstN,
    input  logic notEmpty,
    input  logic regStall,
    input  logic isMDFT,
    input  logic mduBusy,
    output logic pop,
    output logic creditReturn,
    output logic issueFire
);
    import mipsPkg::*;

    issueStateT state;
    issueStateT nextState;
    logic       mdStall;

    // HI/LO access has to wait for the running operation
    assign mdStall = isMDFT && mduBusy;

    always_comb begin
        nextState = state;
        case (state)
            // A held multiply/divide keeps waiting on the unit first
            MDUWAIT: begin
                if (!notEmpty) begin
                    nextState = IDLE;
                end else if (mdStall) begin
                    nextState = MDUWAIT;
                end else if (regStall) begin
                    nextState = HAZARD;
                end else begin
                    nextState = ISSUE;
                end
            end
            IDLE, ISSUE, HAZARD: begin
                if (!notEmpty) begin
                    nextState = IDLE;
                end else if (regStall) begin
                    nextState = HAZARD;
                end else if (mdStall) begin
                    nextState = MDUWAIT;
                end else begin
                    nextState = ISSUE;
                end
            end
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Head leaves the queue in the same cycle it is chosen
    assign issueFire    = (nextState == ISSUE);
    assign pop          = issueFire;
    assign creditReturn = issueFire;

endmodule

/* InstrQueue.sv */
`timescale 1ns/100ps

module InstrQueue (
    input  logic           clk,
    input  logic           rstN,
    input  logic           push,
    input  mipsPkg::instrT pushIns,
    input  mipsPkg::wordT  pushRs,
    input  mipsPkg::wordT  pushRt,
    input  logic           pop,
    output mipsPkg::instrT headIns,
    output mipsPkg::wordT  headRs,
    output mipsPkg::wordT  headRt,
    output logic           notEmpty
);
    import mipsPkg::*;

    instrT             insMem [QUEUE_DEPTH];
    wordT              rsMem  [QUEUE_DEPTH];
    wordT              rtMem  [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wrPtr;
    logic [QPTR_W-1:0] rdPtr;
    logic [QPTR_W:0]   count;
    logic              doPop;

    // Credits keep the sender from pushing into a full queue
    assign doPop    = pop && notEmpty;
    assign notEmpty = (count != '0);

    assign headIns = insMem[rdPtr];
    assign headRs  = rsMem[rdPtr];
    assign headRt  = rtMem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            insMem[wrPtr] <= pushIns;
            rsMem[wrPtr]  <= pushRs;
            rtMem[wrPtr]  <= pushRt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (push && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* Controller.sv */
`timescale 1ns/100ps

module Controller (
    input  mipsPkg::instrT   ins,
    // Decode stage
    output logic             isJReg,
    output logic             isJ,
    output logic             isBranch,
    output logic             cmpSelect,
    output logic             isMDFT,
    output logic             linkSelect,
    output mipsPkg::regAddrT a3,
    output mipsPkg::tStageT  tuseRs,
    output mipsPkg::tStageT  tuseRt,
    output mipsPkg::tStageT  tnew,
    // Execute stage
    output logic             aluB,
    output logic             aluImmExt,
    output mipsPkg::aluOpT   aluOp,
    output logic             mduStart,
    output mipsPkg::mduOpT   mduOp,
    output logic             hiWrite,
    output logic             loWrite,
    output logic [1:0]       outSelectE,
    // Memory stage
    output logic             dmWe,
    output mipsPkg::widthT   dmWidth,
    output logic             outSelectM,
    // Source usage
    output logic             isReadRs,
    output logic             isReadRt
);
    import mipsPkg::*;

    logic [5:0] op;
    logic [5:0] func;
    logic       rType;
    logic       add, sub, andR, orR, slt, sltu;
    logic       mult, multu, div, divu;
    logic       mfhi, mflo, mthi, mtlo, jr, jalr;
    logic       addi, andi, ori, lui, beq, bne;
    logic       lw, lh, lb, sw, sh, sb, lwer, j, jal;
    logic       isCalR, isMd, isMf, isMt, isCalI, isLoad, isStore, isLink;

    assign op    = ins[31:26];
    assign func  = ins[5:0];
    assign rType = (op == OP_RTYPE);

    // R-type by function code
    assign add   = rType && (func == FN_ADD);
    assign sub   = rType && (func == FN_SUB);
    assign andR  = rType && (func == FN_AND);
    assign orR   = rType && (func == FN_OR);
    assign slt   = rType && (func == FN_SLT);
    assign sltu  = rType && (func == FN_SLTU);
    assign mult  = rType && (func == FN_MULT);
    assign multu = rType && (func == FN_MULTU);
    assign div   = rType && (func == FN_DIV);
    assign divu  = rType && (func == FN_DIVU);
    assign mfhi  = rType && (func == FN_MFHI);
    assign mflo  = rType && (func == FN_MFLO);
    assign mthi  = rType && (func == FN_MTHI);
    assign mtlo  = rType && (func == FN_MTLO);
    assign jr    = rType && (func == FN_JR);
    assign jalr  = rType && (func == FN_JALR);

    // I-type and J-type by opcode
    assign addi = (op == OP_ADDI);
    assign andi = (op == OP_ANDI);
    assign ori  = (op == OP_ORI);
    assign lui  = (op == OP_LUI);
    assign beq  = (op == OP_BEQ);
    assign bne  = (op == OP_BNE);
    assign lw   = (op == OP_LW);
    assign lh   = (op == OP_LH);
    assign lb   = (op == OP_LB);
    assign sw   = (op == OP_SW);
    assign sh   = (op == OP_SH);
    assign sb   = (op == OP_SB);
    assign lwer = (op == OP_LWER);
    assign j    = (op == OP_J);
    assign jal  = (op == OP_JAL);

    // Instruction classes
    assign isCalR   = add || sub || andR || orR || slt || sltu;
    assign isMd     = mult || multu || div || divu;
    assign isMf     = mfhi || mflo;
    assign isMt     = mthi || mtlo;
    assign isJReg   = jr || jalr;
    assign isCalI   = addi || andi || ori || lui;
    assign isBranch = beq || bne;
    assign isLoad   = lw || lh || lb;
    assign isStore  = sw || sh || sb;
    assign isLink   = jal || jalr;
    assign isJ      = j || jal;

    assign cmpSelect  = !beq;
    assign isMDFT     = isMd || isMf || isMt;
    assign linkSelect = isLink;

    // lwer picks its target late, so it reports no destination
    assign a3 = (isCalR || isMf)  ? ins[15:11] :
                (isCalI || isLoad) ? ins[20:16] :
                isLink             ? 5'd31 :
                                     5'd0;

    assign tuseRs = (isJReg || isBranch) ? 2'd0 :
                    (isCalR || isMd || isMt || isCalI || isLoad || isStore || lwer) ? 2'd1 :
                    2'd3;
    assign tuseRt = isBranch           ? 2'd0 :
                    (isCalR || isMd)   ? 2'd1 :
                    (isStore || lwer)  ? 2'd2 :
                                         2'd3;
    assign tnew   = (isLoad || lwer)           ? 2'd3 :
                    (isCalR || isMf || isCalI) ? 2'd2 :
                    isLink                     ? 2'd1 :
                                                 2'd0;

    assign aluB      = isCalI || isLoad || isStore || lwer;
    assign aluImmExt = addi || isLoad || isStore || lwer;
    assign aluOp     = sub            ? 4'd1 :
                       (andR || andi) ? 4'd2 :
                       (orR || ori)   ? 4'd3 :
                       lui            ? 4'd4 :
                       slt            ? 4'd5 :
                       sltu           ? 4'd6 :
                                        4'd0;

    assign mduStart   = isMd;
    assign mduOp      = divu ? MDU_DIVU : div ? MDU_DIV : multu ? MDU_MULTU : MDU_MULT;
    assign hiWrite    = mthi;
    assign loWrite    = mtlo;
    assign outSelectE = mflo ? 2'd3 : mfhi ? 2'd2 : (isCalR || isCalI) ? 2'd1 : 2'd0;

    assign dmWe       = isStore;
    assign dmWidth    = (sb || lb) ? 2'd2 : (sh || lh) ? 2'd1 : 2'd0;
    assign outSelectM = isLoad || lwer;

    assign isReadRs = isCalR || isMd || isMt || isJReg || isCalI || isBranch
                      || isLoad || isStore || lwer;
    assign isReadRt = isCalR || isMd || isBranch || isStore || lwer;

endmodule

/* mipsPkg.sv */
package mipsPkg;

    typedef logic [31:0] instrT;
    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;
    typedef logic [1:0]  tStageT;
    typedef logic [3:0]  aluOpT;
    typedef logic [2:0]  mduOpT;
    typedef logic [1:0]  widthT;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        HAZARD,
        MDUWAIT
    } issueStateT;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'b000_000;
    localparam logic [5:0] OP_ADDI  = 6'b001_000;
    localparam logic [5:0] OP_ANDI  = 6'b001_100;
    localparam logic [5:0] OP_ORI   = 6'b001_101;
    localparam logic [5:0] OP_LUI   = 6'b001_111;
    localparam logic [5:0] OP_BEQ   = 6'b000_100;
    localparam logic [5:0] OP_BNE   = 6'b000_101;
    localparam logic [5:0] OP_LW    = 6'b100_011;
    localparam logic [5:0] OP_LH    = 6'b100_001;
    localparam logic [5:0] OP_LB    = 6'b100_000;
    localparam logic [5:0] OP_SW    = 6'b101_011;
    localparam logic [5:0] OP_SH    = 6'b101_001;
    localparam logic [5:0] OP_SB    = 6'b101_000;
    localparam logic [5:0] OP_LWER  = 6'b111_100;
    localparam logic [5:0] OP_J     = 6'b000_010;
    localparam logic [5:0] OP_JAL   = 6'b000_011;

    // Function codes of R-type
    localparam logic [5:0] FN_ADD   = 6'b100_000;
    localparam logic [5:0] FN_SUB   = 6'b100_010;
    localparam logic [5:0] FN_AND   = 6'b100_100;
    localparam logic [5:0] FN_OR    = 6'b100_101;
    localparam logic [5:0] FN_SLT   = 6'b101_010;
    localparam logic [5:0] FN_SLTU  = 6'b101_011;
    localparam logic [5:0] FN_MULT  = 6'b011_000;
    localparam logic [5:0] FN_MULTU = 6'b011_001;
    localparam logic [5:0] FN_DIV   = 6'b011_010;
    localparam logic [5:0] FN_DIVU  = 6'b011_011;
    localparam logic [5:0] FN_MFHI  = 6'b010_000;
    localparam logic [5:0] FN_MTHI  = 6'b010_001;
    localparam logic [5:0] FN_MFLO  = 6'b010_010;
    localparam logic [5:0] FN_MTLO  = 6'b010_011;
    localparam logic [5:0] FN_JR    = 6'b001_000;
    localparam logic [5:0] FN_JALR  = 6'b001_001;

    localparam mduOpT MDU_MULT  = 3'd0;
    localparam mduOpT MDU_MULTU = 3'd1;
    localparam mduOpT MDU_DIV   = 3'd2;
    localparam mduOpT MDU_DIVU  = 3'd3;

    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int MULT_CYCLES = 5;
    localparam int DIV_CYCLES  = 10;
    localparam int MDU_CNT_W   = $clog2(DIV_CYCLES + 1);

endpackage
